// ==== dv/tetris_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module tetris_props import tetris_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      cmd_ready,
  input logic      row_valid,
  input logic      row_ready,
  input row_t      row_data,
  input row_addr_t row_addr,
  input bus_req_t  fsm_req,
  input bus_req_t  clr_req,
  input bus_req_t  scan_req,
  input bus_rsp_t  fsm_rsp,
  input bus_rsp_t  clr_rsp,
  input bus_rsp_t  scan_rsp
);

  // a granted read per peer
  logic rd_fsm;
  logic rd_clr;
  logic rd_scan;

  assign rd_fsm  = fsm_rsp.gnt && fsm_req.req && !fsm_req.we;
  assign rd_clr  = clr_rsp.gnt && clr_req.req && !clr_req.we;
  assign rd_scan = scan_rsp.gnt && scan_req.req && !scan_req.we;

  ////////////////////////////////////////////////////////////
  // arbiter
  ////////////////////////////////////////////////////////////
  one_gnt: assert property (@(posedge clk) disable iff (rst)
    $onehot0({fsm_rsp.gnt, clr_rsp.gnt, scan_rsp.gnt}))
    else $error("more than one grant");

  rvalid_after_read: assert property (@(posedge clk) disable iff (rst)
    (fsm_rsp.rvalid |-> $past(rd_fsm)) and (clr_rsp.rvalid |-> $past(rd_clr)) and
    (scan_rsp.rvalid |-> $past(rd_scan)))
    else $error("rvalid without a granted read");

  ////////////////////////////////////////////////////////////
  // streams
  ////////////////////////////////////////////////////////////
  row_hold: assert property (@(posedge clk) disable iff (rst)
    row_valid && !row_ready |=> row_valid && $stable(row_data) && $stable(row_addr))
    else $error("frame row changed under back-pressure");

  ready_low_after_reset: assert property (@(posedge clk) $past(rst) |-> !cmd_ready)
    else $error("cmd_ready high right after reset");

endmodule

bind tetris_top tetris_props props_i (
  .clk       (clk),
  .rst       (rst),
  .cmd_ready (cmd_ready),
  .row_valid (row_valid),
  .row_ready (row_ready),
  .row_data  (row_data),
  .row_addr  (row_addr),
  .fsm_req   (fsm_req),
  .clr_req   (clr_req),
  .scan_req  (scan_req),
  .fsm_rsp   (fsm_rsp),
  .clr_rsp   (clr_rsp),
  .scan_rsp  (scan_rsp)
);

`default_nettype wire

// ==== dv/tetris_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module tetris_tb import tetris_pkg::*; ;

  localparam int ready_limit = 4000;  // cycles for a full drop plus clear
  localparam int row_limit   = 400;   // cycles per row under back-pressure

  logic        clk;
  logic        rst;
  logic        cmd_valid;
  cmd_t        cmd;
  logic        cmd_ready;
  logic        game_over;
  logic [15:0] lines;
  logic        frame_req;
  logic        row_valid;
  logic        row_ready;
  row_t        row_data;
  row_addr_t   row_addr;

  row_t        exp_rows [board_rows];  // expected frame from the trace
  int          sweep_cycles;           // reset release to first cmd_ready

  tetris_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .game_over (game_over),
    .lines     (lines),
    .frame_req (frame_req),
    .row_valid (row_valid),
    .row_ready (row_ready),
    .row_data  (row_data),
    .row_addr  (row_addr)
  );

  always #4 clk = ~clk;  // 8 ns period

  ////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input string name, input logic [31:0] got,
                       input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      abort_run("value mismatch");
    end
  endtask

  // one clock and then 1 ns past the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // command stream
  ////////////////////////////////////////////////////////////
  task automatic wait_cmd_ready();
    int n;
    n = 0;
    while (!cmd_ready) begin
      if (n == ready_limit) abort_run("timeout waiting for cmd_ready");
      next_cycle();
      n++;
    end
  endtask

  task automatic send_cmd(input cmd_op_t op, input piece_t pc);
    int n;
    logic taken;
    n     = 0;
    taken = 1'b0;
    wait_cmd_ready();
    cmd_valid = 1'b1;
    cmd.op    = op;
    cmd.piece = pc;
    while (!taken) begin
      if (n == ready_limit) abort_run("timeout waiting for a command transfer");
      taken = cmd_ready;  // transfers at the coming edge
      next_cycle();
      n++;
    end
    cmd_valid = 1'b0;
    wait_cmd_ready();  // command has taken effect
  endtask

  ////////////////////////////////////////////////////////////
  // frame stream with ready dropped at random
  ////////////////////////////////////////////////////////////
  task automatic read_frame();
    int n;
    frame_req = 1'b1;
    next_cycle();
    frame_req = 1'b0;
    for (int r = 0; r < board_rows; r++) begin
      n = 0;
      row_ready = ($urandom % 4) != 0;
      while (!(row_valid && row_ready)) begin
        if (n == row_limit) abort_run("timeout waiting for a frame row");
        next_cycle();
        row_ready = ($urandom % 4) != 0;
        n++;
      end
      check("row_addr", 32'(row_addr), 32'(r));
      check("row_data", 32'(row_data), 32'(exp_rows[r]));
      next_cycle();
    end
    row_ready = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // trace playback
  ////////////////////////////////////////////////////////////
  task automatic run_trace();
    int    fd;
    int    n;
    int    op_v;
    int    pc_v;
    int    cnt;
    logic  [31:0] exp_lines;
    logic  [31:0] exp_over;
    string tok;
    string rest;
    logic  done;
    fd   = $fopen("dv/tetris_trace.txt", "r");
    done = 1'b0;
    if (fd == 0) abort_run("cannot open dv/tetris_trace.txt");
    while (!done) begin
      tok = "";
      n   = $fscanf(fd, "%s", tok);
      if (n != 1) begin
        done = 1'b1;  // end of file
      end else if (tok.substr(0, 0) == "#") begin
        n = $fgets(rest, fd);
      end else if (tok == "cmd") begin
        n = $fscanf(fd, "%d %d %d", op_v, pc_v, cnt);
        if (n != 3) abort_run("malformed cmd line in trace");
        for (int i = 0; i < cnt; i++) begin
          send_cmd(cmd_op_t'(op_v[2:0]), piece_t'(pc_v[2:0]));
        end
      end else if (tok == "frame") begin
        for (int r = 0; r < board_rows; r++) begin
          n = $fscanf(fd, "%h", exp_rows[r]);
          if (n != 1) abort_run("frame in trace has too few rows");
        end
        read_frame();
      end else if (tok == "status") begin
        n = $fscanf(fd, "%h %h", exp_lines, exp_over);
        if (n != 2) abort_run("malformed status line in trace");
        check("lines", 32'(lines), exp_lines);
        check("game_over", 32'(game_over), exp_over);
      end else begin
        abort_run("unknown keyword in trace");
      end
    end
    $fclose(fd);
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    cmd_valid    = 1'b0;
    cmd          = '0;
    frame_req    = 1'b0;
    row_ready    = 1'b0;
    sweep_cycles = 0;
    void'($urandom(32'hffb5));
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    // zero sweep of the board memory, one row per cycle
    while (!cmd_ready) begin
      if (sweep_cycles == ready_limit) abort_run("timeout waiting for the reset sweep");
      next_cycle();
      sweep_cycles++;
    end
    check("sweep_cycles", 32'(sweep_cycles), 32'(board_rows));
    run_trace();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/tetris_trace.txt ====
# cmd <op> <piece> <repeat>  op 0 spawn 1 left 2 right 3 rot_r 4 rot_l 5 down 6 hard_drop
# frame <21 rows hex, row 0 first>   status <lines hex> <game_over>
status 0 0
frame 0 0 0 0 0 0 0
 0 0 0 0 0 0 0
 0 0 0 0 0 0 0
# I piece pushed past the left wall
cmd 0 1 1
cmd 1 0 5
cmd 6 0 1
frame 0 0 0 0 0 0 0
 0 0 0 0 0 0 0
 0 0 0 0 0 0 00000249
# second I, then an O at the right wall fills row 20
cmd 0 1 1
cmd 2 0 1
cmd 6 0 1
cmd 0 2 1
cmd 2 0 6
cmd 5 0 1
cmd 6 0 1
status 1 0
frame 0 0 0 0 0 0 0
 0 0 0 0 0 0 0
 0 0 0 0 0 0 12000000
# T turned twice, then a T whose rotations hit the wall
cmd 0 3 1
cmd 3 0 2
cmd 6 0 1
cmd 0 3 1
cmd 3 0 1
cmd 1 0 5
cmd 3 0 1
cmd 4 0 1
cmd 6 0 1
frame 0 0 0 0 0 0 0
 0 0 0 0 0 0 0
 0 0 0 0 00000018 0000301b 1201b618
# O pieces stacked in one column until a spawn collides
cmd 0 2 1
cmd 6 0 1
cmd 0 2 1
cmd 6 0 1
cmd 0 2 1
cmd 6 0 1
cmd 0 2 1
cmd 6 0 1
cmd 0 2 1
cmd 6 0 1
cmd 0 2 1
cmd 6 0 1
cmd 0 2 1
cmd 6 0 1
cmd 0 2 1
cmd 6 0 1
cmd 0 2 1
cmd 6 0 1
cmd 0 2 1
status 1 1
cmd 1 0 1
cmd 0 1 1
cmd 6 0 1
status 1 1
frame 0 00002400 00002400 00002400 00002400 00002400 00002400
 00002400 00002400 00002400 00002400 00002400 00002400 00002400
 00002400 00002400 00002400 00002400 00002418 0000301b 1201b618

// ==== hw/board_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module board_arbiter import tetris_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      init_done,
  input  bus_req_t  fsm_req,
  input  bus_req_t  clr_req,
  input  bus_req_t  scan_req,
  output bus_rsp_t  fsm_rsp,
  output bus_rsp_t  clr_rsp,
  output bus_rsp_t  scan_rsp,
  output logic      mem_we,
  output row_addr_t mem_addr,
  output row_t      mem_wdata,
  input  row_t      mem_rdata
);

  // one-hot vectors: bit 0 line clear, bit 1 controller, bit 2 scanout
  logic [2:0] gnt;
  logic [2:0] owner;     // locked holder, zero when free
  logic [2:0] rd_owner;  // who read in the last cycle
  bus_req_t   sel;       // request of the granted peer

  ////////////////////////////////////////////////////////////
  // grant
  ////////////////////////////////////////////////////////////
  always_comb begin
    gnt = '0;
    if (init_done) begin
      if (|owner) gnt = owner;               // held even with req low
      else if (clr_req.req) gnt = 3'b001;
      else if (fsm_req.req) gnt = 3'b010;
      else if (scan_req.req) gnt = 3'b100;
    end
  end

  always_comb begin
    case (gnt)
      3'b001:  sel = clr_req;
      3'b010:  sel = fsm_req;
      3'b100:  sel = scan_req;
      default: sel = '0;
    endcase
  end

  assign mem_we    = sel.req & sel.we;  // a locked owner may idle a cycle
  assign mem_addr  = sel.addr;
  assign mem_wdata = sel.wdata;

  ////////////////////////////////////////////////////////////
  // lock owner and read return
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      owner    <= '0;
      rd_owner <= '0;
    end else begin
      owner    <= sel.lock ? gnt : '0;
      rd_owner <= (sel.req && !sel.we) ? gnt : '0;
    end
  end

  assign clr_rsp  = '{gnt: gnt[0], rvalid: rd_owner[0], rdata: mem_rdata};
  assign fsm_rsp  = '{gnt: gnt[1], rvalid: rd_owner[1], rdata: mem_rdata};
  assign scan_rsp = '{gnt: gnt[2], rvalid: rd_owner[2], rdata: mem_rdata};

endmodule

`default_nettype wire

// ==== hw/board_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module board_mem import tetris_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      we,
  input  row_addr_t addr,
  input  row_t      wdata,
  output row_t      rdata,
  output logic      init_done
);

  row_t      mem [board_rows];
  row_addr_t sweep_addr;   // row being zeroed after reset

  // zero sweep, one row per cycle
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      sweep_addr <= '0;
      init_done  <= 1'b0;
    end else if (!init_done) begin
      if (sweep_addr == row_addr_t'(board_rows - 1)) init_done <= 1'b1;
      sweep_addr <= sweep_addr + 1'b1;
    end
  end

  // storage and registered read
  always_ff @(posedge clk) begin
    if (!init_done) begin
      mem[sweep_addr] <= '0;
    end else if (we && addr < board_rows) begin
      mem[addr] <= wdata;
    end
    rdata <= (addr < board_rows) ? mem[addr] : '0;  // rows past 20 read empty
  end

endmodule

`default_nettype wire

// ==== hw/line_clear.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_clear import tetris_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        clear_start,
  output logic        clear_done,
  output logic [2:0]  n_cleared,
  output logic [15:0] lines,
  output bus_req_t    bus_req,
  input  bus_rsp_t    bus_rsp
);

  typedef enum logic [2:0] {
    CL_IDLE, CL_READ, CL_WAIT, CL_WRITE, CL_FILL, CL_DONE
  } clr_state_t;

  clr_state_t state;
  clr_state_t walk_next;
  row_addr_t  rd_ptr;    // row being examined, walks up
  row_addr_t  wr_ptr;    // next row to keep into, all ones once past row 0
  row_t       row_buf;
  logic [2:0] n_cnt;
  logic       full;

  always_comb begin
    full = 1'b1;
    for (int c = 0; c < board_cols; c++) begin
      if (bus_rsp.rdata[3*c +: 3] == '0) full = 1'b0;
    end
  end

  assign walk_next  = (rd_ptr == '0) ? CL_FILL : CL_READ;
  assign clear_done = (state == CL_DONE);
  assign n_cleared  = n_cnt;

  ////////////////////////////////////////////////////////////
  // bus, locked for the whole pass
  ////////////////////////////////////////////////////////////
  always_comb begin
    bus_req      = '0;
    bus_req.lock = (state != CL_IDLE) && (state != CL_DONE);
    case (state)
      CL_READ: begin
        bus_req.req  = 1'b1;
        bus_req.addr = rd_ptr;
      end
      CL_WRITE: begin
        bus_req.req   = 1'b1;
        bus_req.we    = 1'b1;
        bus_req.addr  = wr_ptr;
        bus_req.wdata = row_buf;
      end
      CL_FILL: begin
        bus_req.req  = (wr_ptr != '1);  // zeros into the top rows
        bus_req.we   = 1'b1;
        bus_req.addr = wr_ptr;
      end
      default: bus_req.req = 1'b0;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state   <= CL_IDLE;
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      row_buf <= '0;
      n_cnt   <= '0;
      lines   <= '0;
    end else begin
      case (state)
        CL_IDLE: begin
          if (clear_start) begin
            rd_ptr <= row_addr_t'(board_rows - 1);  // bottom row first
            wr_ptr <= row_addr_t'(board_rows - 1);
            n_cnt  <= '0;
            state  <= CL_READ;
          end
        end
        CL_READ: if (bus_rsp.gnt) state <= CL_WAIT;
        CL_WAIT: begin
          if (bus_rsp.rvalid) begin
            row_buf <= bus_rsp.rdata;
            if (full) begin
              n_cnt  <= n_cnt + 1'b1;  // dropped, wr_ptr stays
              rd_ptr <= rd_ptr - 1'b1;
              state  <= walk_next;
            end else if (wr_ptr == rd_ptr) begin
              wr_ptr <= wr_ptr - 1'b1;  // already in place
              rd_ptr <= rd_ptr - 1'b1;
              state  <= walk_next;
            end else begin
              state <= CL_WRITE;
            end
          end
        end
        CL_WRITE: begin
          if (bus_rsp.gnt) begin
            wr_ptr <= wr_ptr - 1'b1;
            rd_ptr <= rd_ptr - 1'b1;
            state  <= walk_next;
          end
        end
        CL_FILL: begin
          if (wr_ptr == '1) state <= CL_DONE;
          else if (bus_rsp.gnt) wr_ptr <= wr_ptr - 1'b1;
        end
        CL_DONE: begin
          lines <= lines + 16'(n_cnt);
          state <= CL_IDLE;
        end
        default: state <= CL_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/row_scanout.sv ====
`timescale 1ns/100ps
`default_nettype none

module row_scanout import tetris_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      frame_req,
  output logic      row_valid,
  input  logic      row_ready,
  output row_t      row_data,
  output row_addr_t row_addr,
  output bus_req_t  bus_req,
  input  bus_rsp_t  bus_rsp
);

  typedef enum logic [1:0] {SC_IDLE, SC_READ, SC_WAIT, SC_SHOW} scan_state_t;

  scan_state_t state;

  assign row_valid = (state == SC_SHOW);

  // plain reads, no lock, lowest priority
  always_comb begin
    bus_req      = '0;
    bus_req.req  = (state == SC_READ);
    bus_req.addr = row_addr;
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state    <= SC_IDLE;
      row_addr <= '0;
    end else begin
      case (state)
        SC_IDLE: begin
          if (frame_req) begin
            row_addr <= '0;
            state    <= SC_READ;
          end
        end
        SC_READ: if (bus_rsp.gnt) state <= SC_WAIT;  // retries when preempted
        SC_WAIT: if (bus_rsp.rvalid) state <= SC_SHOW;
        SC_SHOW: begin
          if (row_ready) begin
            if (row_addr == row_addr_t'(board_rows - 1)) begin
              state <= SC_IDLE;
            end else begin
              row_addr <= row_addr + 1'b1;
              state    <= SC_READ;
            end
          end
        end
        default: state <= SC_IDLE;
      endcase
    end
  end

  // captured row, held through back-pressure
  always_ff @(posedge clk) begin
    if (state == SC_WAIT && bus_rsp.rvalid) row_data <= bus_rsp.rdata;
  end

endmodule

`default_nettype wire

// ==== hw/tetris_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module tetris_fsm import tetris_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     cmd_valid,
  input  cmd_t     cmd,
  output logic     cmd_ready,
  output logic     game_over,
  output bus_req_t bus_req,
  input  bus_rsp_t bus_rsp,
  output logic     clear_start,
  input  logic     clear_done,
  input  logic     init_done
);

  fsm_state_t state;
  cmd_op_t    op;        // command in flight
  logic       active;    // a piece is falling
  logic       locking;   // second pass, merging the piece into the board
  logic [2:0] idx;       // frame row under test, 4 when all rows are done
  logic       accept;
  logic       collide;

  // active piece
  piece_t     act_piece;
  rot_t       act_rot;
  row_addr_t  act_row;
  col_t       act_col;

  // candidate position
  piece_t     cand_piece;
  rot_t       cand_rot;
  row_addr_t  cand_row;
  col_t       cand_col;

  logic [15:0]           cand_mask;
  logic [3:0]            mrow;        // bit 3 = frame column 0
  row_addr_t             cell_row;
  col_t                  cx;
  logic [board_cols-1:0] prow;        // board columns hit in this row
  logic [board_cols-1:0] occ;
  logic                  oob;
  logic                  off_bottom;
  logic                  hit;
  logic                  fetch_go;
  row_t                  merged;
  row_t                  row_buf;     // row to write back while locking

  assign cmd_ready = init_done && (state == IDLE || state == OVER);
  assign accept    = cmd_valid && cmd_ready;
  assign game_over = (state == OVER);

  ////////////////////////////////////////////////////////////
  // candidate geometry for the current frame row
  ////////////////////////////////////////////////////////////
  assign cand_mask  = piece_mask(cand_piece, cand_rot);
  assign mrow       = cand_mask[15-4*idx[1:0] -: 4];
  assign cell_row   = cand_row + row_addr_t'(idx[1:0]);
  assign off_bottom = cell_row > row_addr_t'(board_rows - 1);

  always_comb begin
    prow = '0;
    oob  = 1'b0;
    cx   = cand_col;
    for (int dx = 0; dx < 4; dx++) begin
      cx = cand_col + col_t'(dx);
      if (mrow[3-dx]) begin
        if (cx < 0 || cx > col_t'(board_cols - 1)) oob = 1'b1;  // past a wall
        else prow[cx[3:0]] = 1'b1;
      end
    end
  end

  // occupancy of the returned row, and the row with the piece painted in
  always_comb begin
    merged = bus_rsp.rdata;
    for (int c = 0; c < board_cols; c++) begin
      occ[c] = |bus_rsp.rdata[3*c +: 3];
      if (prow[c]) merged[3*c +: 3] = color_t'(cand_piece);
    end
  end

  assign hit      = |(occ & prow);
  assign fetch_go = !idx[2] && mrow != 4'd0 && !oob && !off_bottom;

  // no collisions while locking, the current spot is known to be free
  assign collide = !locking &&
                   ((state == FETCH && !idx[2] && mrow != 4'd0 && (oob || off_bottom)) ||
                    (state == CHECK && bus_rsp.rvalid && hit));

  ////////////////////////////////////////////////////////////
  // board bus, lock held over a whole check or lock pass
  ////////////////////////////////////////////////////////////
  always_comb begin
    bus_req       = '0;
    bus_req.addr  = cell_row;
    bus_req.wdata = row_buf;
    case (state)
      FETCH: begin
        bus_req.lock = 1'b1;
        bus_req.req  = fetch_go;
      end
      CHECK: bus_req.lock = 1'b1;  // waiting for rvalid
      COMMIT: begin
        bus_req.lock = 1'b1;
        bus_req.req  = 1'b1;
        bus_req.we   = 1'b1;
      end
      default: bus_req.lock = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // controller
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state       <= IDLE;
      op          <= SPAWN;
      active      <= 1'b0;
      locking     <= 1'b0;
      idx         <= '0;
      clear_start <= 1'b0;
      act_piece   <= PC_I;
      act_rot     <= '0;
      act_row     <= '0;
      act_col     <= '0;
      cand_piece  <= PC_I;
      cand_rot    <= '0;
      cand_row    <= '0;
      cand_col    <= '0;
      row_buf     <= '0;
    end else begin
      clear_start <= 1'b0;
      if (collide) begin
        case (op)
          SPAWN:           state <= OVER;
          DOWN, HARD_DROP: state <= LOCK;  // blocked step locks the piece
          default:         state <= IDLE;  // blocked move is dropped
        endcase
      end else begin
        case (state)
          IDLE: begin
            if (accept && (cmd.op == SPAWN || active)) begin
              op         <= cmd.op;
              idx        <= '0;
              cand_piece <= act_piece;
              cand_rot   <= act_rot;
              cand_row   <= act_row;
              cand_col   <= act_col;
              case (cmd.op)
                SPAWN: begin
                  cand_piece <= cmd.piece;
                  cand_rot   <= '0;
                  cand_row   <= '0;
                  cand_col   <= col_t'(3);
                end
                LEFT:    cand_col <= act_col - col_t'(1);
                RIGHT:   cand_col <= act_col + col_t'(1);
                ROT_R:   cand_rot <= act_rot + 1'b1;
                ROT_L:   cand_rot <= act_rot - 1'b1;
                default: cand_row <= act_row + 1'b1;  // DOWN, HARD_DROP
              endcase
              state <= FETCH;
            end
          end
          FETCH: begin
            if (idx[2]) begin
              if (locking) begin
                locking     <= 1'b0;
                active      <= 1'b0;
                clear_start <= 1'b1;
                state       <= WAIT_CLEAR;
              end else begin
                // candidate is free, take it
                act_piece <= cand_piece;
                act_rot   <= cand_rot;
                act_row   <= cand_row;
                act_col   <= cand_col;
                active    <= 1'b1;
                if (op == HARD_DROP) begin
                  cand_row <= cand_row + 1'b1;  // try the next step down
                  idx      <= '0;
                end else begin
                  state <= IDLE;
                end
              end
            end else if (mrow == 4'd0) begin
              idx <= idx + 1'b1;  // empty frame row, nothing to read
            end else if (bus_rsp.gnt) begin
              state <= CHECK;
            end
          end
          CHECK: begin
            if (bus_rsp.rvalid) begin
              if (locking) begin
                row_buf <= merged;
                state   <= COMMIT;
              end else begin
                idx   <= idx + 1'b1;
                state <= FETCH;
              end
            end
          end
          COMMIT: begin
            if (bus_rsp.gnt) begin
              idx   <= idx + 1'b1;
              state <= FETCH;
            end
          end
          LOCK: begin
            // rerun the rows at the resting spot, writing this time
            cand_piece <= act_piece;
            cand_rot   <= act_rot;
            cand_row   <= act_row;
            cand_col   <= act_col;
            locking    <= 1'b1;
            idx        <= '0;
            state      <= FETCH;
          end
          WAIT_CLEAR: if (clear_done) state <= IDLE;
          OVER: state <= OVER;  // commands taken and ignored until reset
          default: state <= IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/tetris_pkg.sv ====
`default_nettype none

package tetris_pkg;

  ////////////////////////////////////////////////////////////
  // board geometry and cell types
  ////////////////////////////////////////////////////////////
  localparam int board_rows = 21;  // row 0 at the top
  localparam int board_cols = 10;  // col 0 at the left

  typedef logic [2:0]              color_t;     // 0 = empty
  typedef logic [4:0]              row_addr_t;
  typedef logic signed [4:0]       col_t;       // may step past the left wall
  typedef logic [3*board_cols-1:0] row_t;       // cell c at bits 3c+2:3c
  typedef logic [1:0]              rot_t;       // clockwise quarter turns

  // piece code doubles as its colour
  typedef enum logic [2:0] {
    PC_I = 3'd1, PC_O, PC_T, PC_S, PC_Z, PC_J, PC_L
  } piece_t;

  typedef enum logic [2:0] {
    SPAWN, LEFT, RIGHT, ROT_R, ROT_L, DOWN, HARD_DROP
  } cmd_op_t;

  typedef struct packed {
    cmd_op_t op;
    piece_t  piece;   // SPAWN only
  } cmd_t;

  ////////////////////////////////////////////////////////////
  // board bus
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic      req;
    logic      lock;   // keep the grant across accesses
    logic      we;
    row_addr_t addr;
    row_t      wdata;
  } bus_req_t;

  typedef struct packed {
    logic gnt;
    logic rvalid;  // one cycle after a granted read
    row_t rdata;
  } bus_rsp_t;

  typedef enum logic [2:0] {
    IDLE, FETCH, CHECK, COMMIT, LOCK, WAIT_CLEAR, OVER
  } fsm_state_t;

  // 4x4 occupancy, row-major, frame cell (y,x) at bit 15-4y-x
  function automatic logic [15:0] piece_mask(piece_t p, rot_t r);
    logic [15:0] m;
    logic [15:0] t;
    int          n;   // side of the box the shape turns in
    n = 3;
    case (p)
      PC_I: begin
        m = 16'b1111_0000_0000_0000;
        n = 4;
      end
      PC_O: begin
        m = 16'b1100_1100_0000_0000;
        n = 2;
      end
      PC_T: m = 16'b1110_0100_0000_0000;  // flat edge on top
      PC_S: m = 16'b0110_1100_0000_0000;
      PC_Z: m = 16'b1100_0110_0000_0000;
      PC_J: m = 16'b1000_1110_0000_0000;
      PC_L: m = 16'b0010_1110_0000_0000;
      default: m = '0;
    endcase
    // one clockwise turn per step: new(y,x) = old(n-1-x, y)
    for (int k = 0; k < 3; k++) begin
      if (k < int'(r)) begin
        t = '0;
        for (int y = 0; y < 4; y++) begin
          for (int x = 0; x < 4; x++) begin
            if (y < n && x < n) t[15-4*y-x] = m[15-4*(n-1-x)-y];
          end
        end
        m = t;
      end
    end
    return m;
  endfunction

endpackage

`default_nettype wire

// ==== hw/tetris_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tetris_top import tetris_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        cmd_valid,
  input  cmd_t        cmd,
  output logic        cmd_ready,
  output logic        game_over,
  output logic [15:0] lines,
  input  logic        frame_req,
  output logic        row_valid,
  input  logic        row_ready,
  output row_t        row_data,
  output row_addr_t   row_addr
);

  ////////////////////////////////////////////////////////////
  // memory side
  ////////////////////////////////////////////////////////////
  logic      mem_we;
  row_addr_t mem_addr;
  row_t      mem_wdata;
  row_t      mem_rdata;
  logic      init_done;  // zero sweep finished

  // one bus per peer
  bus_req_t  fsm_req, clr_req, scan_req;
  bus_rsp_t  fsm_rsp, clr_rsp, scan_rsp;

  logic      clear_start;
  logic      clear_done;

  board_mem board_mem_i (
    .clk       (clk),
    .rst       (rst),
    .we        (mem_we),
    .addr      (mem_addr),
    .wdata     (mem_wdata),
    .rdata     (mem_rdata),
    .init_done (init_done)
  );

  board_arbiter board_arbiter_i (
    .clk       (clk),
    .rst       (rst),
    .init_done (init_done),
    .fsm_req   (fsm_req),
    .clr_req   (clr_req),
    .scan_req  (scan_req),
    .fsm_rsp   (fsm_rsp),
    .clr_rsp   (clr_rsp),
    .scan_rsp  (scan_rsp),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  ////////////////////////////////////////////////////////////
  // peers
  ////////////////////////////////////////////////////////////
  tetris_fsm tetris_fsm_i (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .cmd_ready   (cmd_ready),
    .game_over   (game_over),
    .bus_req     (fsm_req),
    .bus_rsp     (fsm_rsp),
    .clear_start (clear_start),
    .clear_done  (clear_done),
    .init_done   (init_done)
  );

  // per-lock count stays internal, only the total goes out
  line_clear line_clear_i (
    .clk         (clk),
    .rst         (rst),
    .clear_start (clear_start),
    .clear_done  (clear_done),
    .n_cleared   (),
    .lines       (lines),
    .bus_req     (clr_req),
    .bus_rsp     (clr_rsp)
  );

  row_scanout row_scanout_i (
    .clk       (clk),
    .rst       (rst),
    .frame_req (frame_req),
    .row_valid (row_valid),
    .row_ready (row_ready),
    .row_data  (row_data),
    .row_addr  (row_addr),
    .bus_req   (scan_req),
    .bus_rsp   (scan_rsp)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator; exit status is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tetris_tb \
  -f tetris.f \
  -o Vtetris_tb

./obj_dir/Vtetris_tb

// ==== tetris.f ====
hw/tetris_pkg.sv
hw/board_mem.sv
hw/board_arbiter.sv
hw/tetris_fsm.sv
hw/line_clear.sv
hw/row_scanout.sv
hw/tetris_top.sv
dv/tetris_props.sv
dv/tetris_tb.sv
